// ==== rvc_expander_cfg.svh ====
////////////////////////////////////////////////////////////
// build constants for the RV32C instruction expander
// instruction widths and the fixed register numbers that
// the quadrant decoders place into expanded words
// include wherever one of these macros is referenced
////////////////////////////////////////////////////////////
`ifndef RVC_EXPANDER_CFG_SVH
`define RVC_EXPANDER_CFG_SVH

////////////////////////////////////////////////////////////
// instruction widths
////////////////////////////////////////////////////////////

// compressed instruction width
`define RVC_ILEN 16
// full RV32I instruction width
`define RV_ILEN 32

////////////////////////////////////////////////////////////
// fixed register numbers
////////////////////////////////////////////////////////////

// return address, link target of c.jal and c.jalr
`define RV_REG_RA 5'd1
// stack pointer, base of the sp-relative forms
`define RV_REG_SP 5'd2
// 3-bit register fields select x8..x15
`define RVC_PRIME_BASE 5'd8

`endif

// ==== rv32_isa_pkg.sv ====
////////////////////////////////////////////////////////////
// RV32I target encoding used by the expander
// major opcodes, funct3 values and the instruction word
// reference by scoped name from the decoders and top level
////////////////////////////////////////////////////////////
`default_nettype none
`include "rvc_expander_cfg.svh"

package rv32_isa_pkg;

  // full-width instruction word
  typedef logic [`RV_ILEN-1:0] instr_t;

  ////////////////////////////////////////////////////////////
  // major opcodes reached by an expansion
  ////////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    LOAD   = 7'b0000011,
    OP_IMM = 7'b0010011,
    STORE  = 7'b0100011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011,
    JALR   = 7'b1100111,
    JAL    = 7'b1101111,
    SYSTEM = 7'b1110011
  } opcode_e;

  ////////////////////////////////////////////////////////////
  // funct3 for loads, stores, ALU operations and shifts
  ////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    // add, addi and sub share this one
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    // word width for lw and sw
    F3_WORD = 3'b010,
    F3_XOR  = 3'b100,
    // srli and srai, told apart by funct7
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } funct3_e;

  // ebreak has a single fixed encoding
  localparam instr_t EBREAK_WORD = {12'h001, 5'd0, 3'b000, 5'd0, SYSTEM};

endpackage

`default_nettype wire

// ==== rvc_pkg.sv ====
////////////////////////////////////////////////////////////
// compressed side of the expander
// quadrant encoding, the 16-bit instruction type and the
// bundles returned by the decoders and by the top level
////////////////////////////////////////////////////////////
`default_nettype none
`include "rvc_expander_cfg.svh"

package rvc_pkg;

  // low two bits of a fetch word
  typedef enum logic [1:0] {
    Q0   = 2'b00,
    Q1   = 2'b01,
    Q2   = 2'b10,
    // not compressed, 32-bit word
    FULL = 2'b11
  } quadrant_e;

  // compressed instruction word
  typedef logic [`RVC_ILEN-1:0] cinstr_t;

  ////////////////////////////////////////////////////////////
  // result bundles
  ////////////////////////////////////////////////////////////

  // expansion returned by each quadrant decoder
  typedef struct packed {
    rv32_isa_pkg::instr_t instr;
    logic                 illegal;
  } expand_t;

  // registered output of the top level
  typedef struct packed {
    logic                 valid;
    rv32_isa_pkg::instr_t instr;
    logic                 compressed;
    logic                 illegal;
  } decode_out_t;

endpackage

`default_nettype wire

// ==== rvc_decode_q0.sv ====
////////////////////////////////////////////////////////////
// quadrant 0 expansion, purely combinational
// handles c.addi4spn, c.lw and c.sw
// float and reserved slots come back flagged illegal
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "rvc_expander_cfg.svh"

module rvc_decode_q0 (
  input  rvc_pkg::cinstr_t cinstr_i,
  output rvc_pkg::expand_t expand_o
);

  // prime register fields mapped onto x8..x15
  logic [4:0] rs1p;
  logic [4:0] rdp;
  // word offset shared by c.lw and c.sw
  logic [11:0] word_off;

  assign rs1p = `RVC_PRIME_BASE + {2'b00, cinstr_i[9:7]};
  assign rdp  = `RVC_PRIME_BASE + {2'b00, cinstr_i[4:2]};

  assign word_off = {5'b0, cinstr_i[5], cinstr_i[12:10], cinstr_i[6], 2'b00};

  always_comb begin
    expand_o.instr   = '0;
    expand_o.illegal = 1'b0;

    case (cinstr_i[15:13])
      3'b000: begin
        // c.addi4spn -> addi rd', sp, nzuimm
        expand_o.instr = {2'b00, cinstr_i[10:7], cinstr_i[12:11], cinstr_i[5],
                          cinstr_i[6], 2'b00, `RV_REG_SP, rv32_isa_pkg::F3_ADD,
                          rdp, rv32_isa_pkg::OP_IMM};
        // zero immediate is reserved
        if (cinstr_i[12:5] == 8'b0) begin
          expand_o.illegal = 1'b1;
        end
      end

      3'b010: begin
        // c.lw -> lw rd', off(rs1')
        expand_o.instr = {word_off, rs1p, rv32_isa_pkg::F3_WORD, rdp,
                          rv32_isa_pkg::LOAD};
      end

      3'b110: begin
        // c.sw -> sw rs2', off(rs1'), rs2' sits where rd' would
        expand_o.instr = {word_off[11:5], rdp, rs1p, rv32_isa_pkg::F3_WORD,
                          word_off[4:0], rv32_isa_pkg::STORE};
      end

      default: begin
        // fld, flw, fsd, fsw and the reserved slot
        expand_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rvc_decode_q1.sv ====
////////////////////////////////////////////////////////////
// quadrant 1 expansion, purely combinational
// immediate arithmetic, lui, the prime-register ALU group,
// jumps and the compare-with-zero branches
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "rvc_expander_cfg.svh"

module rvc_decode_q1 (
  input  rvc_pkg::cinstr_t cinstr_i,
  output rvc_pkg::expand_t expand_o
);

  // full register field and the prime fields
  logic [4:0]  rd;
  logic [4:0]  rs1p;
  logic [4:0]  rs2p;
  // sign-extended 6-bit immediate of the CI format
  logic [11:0] imm_ci;
  // scrambled immediate in J-type bit order, bits 31:12
  logic [19:0] jal_imm;
  logic [4:0]  jal_rd;
  logic        nzimm_zero;

  assign rd   = cinstr_i[11:7];
  assign rs1p = `RVC_PRIME_BASE + {2'b00, cinstr_i[9:7]};
  assign rs2p = `RVC_PRIME_BASE + {2'b00, cinstr_i[4:2]};

  assign imm_ci     = {{7{cinstr_i[12]}}, cinstr_i[6:2]};
  assign nzimm_zero = ({cinstr_i[12], cinstr_i[6:2]} == 6'b0);

  assign jal_imm = {cinstr_i[12], cinstr_i[8], cinstr_i[10:9], cinstr_i[6],
                    cinstr_i[7], cinstr_i[2], cinstr_i[11], cinstr_i[5:3],
                    {9{cinstr_i[12]}}};
  // c.j leaves the link in x0
  assign jal_rd  = cinstr_i[15] ? 5'd0 : `RV_REG_RA;

  always_comb begin
    expand_o.instr   = '0;
    expand_o.illegal = 1'b0;

    case (cinstr_i[15:13])
      3'b000: begin
        // c.addi, and c.nop when rd is x0
        expand_o.instr = {imm_ci, rd, rv32_isa_pkg::F3_ADD, rd, rv32_isa_pkg::OP_IMM};
      end

      3'b001,
      3'b101: begin
        // c.jal and c.j -> jal
        expand_o.instr = {jal_imm, jal_rd, rv32_isa_pkg::JAL};
      end

      3'b010: begin
        // c.li -> addi rd, x0, imm, a hint when rd is x0
        expand_o.instr = {imm_ci, 5'd0, rv32_isa_pkg::F3_ADD, rd, rv32_isa_pkg::OP_IMM};
      end

      3'b011: begin
        if (rd == `RV_REG_SP) begin
          // c.addi16sp -> addi sp, sp, nzimm*16
          expand_o.instr = {{3{cinstr_i[12]}}, cinstr_i[4:3], cinstr_i[5], cinstr_i[2],
                            cinstr_i[6], 4'b0, `RV_REG_SP, rv32_isa_pkg::F3_ADD,
                            `RV_REG_SP, rv32_isa_pkg::OP_IMM};
        end else begin
          // c.lui
          expand_o.instr = {{15{cinstr_i[12]}}, cinstr_i[6:2], rd, rv32_isa_pkg::LUI};
        end
        expand_o.illegal = nzimm_zero;
      end

      3'b100: begin
        case (cinstr_i[11:10])
          2'b00,
          2'b01: begin
            // c.srli and c.srai, bit 10 selects the arithmetic form
            expand_o.instr = {1'b0, cinstr_i[10], 5'b0, cinstr_i[6:2], rs1p,
                              rv32_isa_pkg::F3_SR, rs1p, rv32_isa_pkg::OP_IMM};
            // shamt[5] does not exist on RV32
            expand_o.illegal = cinstr_i[12];
          end
          2'b10: begin
            // c.andi
            expand_o.instr = {imm_ci, rs1p, rv32_isa_pkg::F3_AND, rs1p,
                              rv32_isa_pkg::OP_IMM};
          end
          default: begin
            case ({cinstr_i[12], cinstr_i[6:5]})
              3'b000: begin
                expand_o.instr = {7'b0100000, rs2p, rs1p, rv32_isa_pkg::F3_ADD, rs1p,
                                  rv32_isa_pkg::OP};
              end
              3'b001: begin
                expand_o.instr = {7'b0, rs2p, rs1p, rv32_isa_pkg::F3_XOR, rs1p,
                                  rv32_isa_pkg::OP};
              end
              3'b010: begin
                expand_o.instr = {7'b0, rs2p, rs1p, rv32_isa_pkg::F3_OR, rs1p,
                                  rv32_isa_pkg::OP};
              end
              3'b011: begin
                expand_o.instr = {7'b0, rs2p, rs1p, rv32_isa_pkg::F3_AND, rs1p,
                                  rv32_isa_pkg::OP};
              end
              default: begin
                // subw and addw on RV64, the rest are Zc slots
                expand_o.illegal = 1'b1;
              end
            endcase
          end
        endcase
      end

      default: begin
        // c.beqz and c.bnez, bit 13 picks bne
        expand_o.instr = {{4{cinstr_i[12]}}, cinstr_i[6:5], cinstr_i[2], 5'd0, rs1p,
                          2'b00, cinstr_i[13], cinstr_i[11:10], cinstr_i[4:3],
                          cinstr_i[12], rv32_isa_pkg::BRANCH};
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rvc_decode_q2.sv ====
////////////////////////////////////////////////////////////
// quadrant 2 expansion, purely combinational
// slli, the sp-relative word load and store, and the
// jr / mv / jalr / add / ebreak group under funct3 100
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "rvc_expander_cfg.svh"

module rvc_decode_q2 (
  input  rvc_pkg::cinstr_t cinstr_i,
  output rvc_pkg::expand_t expand_o
);

  logic [4:0] rd;
  logic [4:0] rs2;
  logic       rd_zero;
  logic       rs2_zero;

  assign rd       = cinstr_i[11:7];
  assign rs2      = cinstr_i[6:2];
  assign rd_zero  = (rd == 5'd0);
  assign rs2_zero = (rs2 == 5'd0);

  always_comb begin
    expand_o.instr   = '0;
    expand_o.illegal = 1'b0;

    case (cinstr_i[15:13])
      3'b000: begin
        // c.slli, shamt zero or rd x0 are hints
        expand_o.instr = {7'b0, rs2, rd, rv32_isa_pkg::F3_SLL, rd, rv32_isa_pkg::OP_IMM};
        expand_o.illegal = cinstr_i[12];
      end

      3'b010: begin
        // c.lwsp -> lw rd, off(sp)
        expand_o.instr = {4'b0, cinstr_i[3:2], cinstr_i[12], cinstr_i[6:4], 2'b00,
                          `RV_REG_SP, rv32_isa_pkg::F3_WORD, rd, rv32_isa_pkg::LOAD};
        // rd x0 is reserved
        expand_o.illegal = rd_zero;
      end

      3'b110: begin
        // c.swsp -> sw rs2, off(sp)
        expand_o.instr = {4'b0, cinstr_i[8:7], cinstr_i[12], rs2, `RV_REG_SP,
                          rv32_isa_pkg::F3_WORD, cinstr_i[11:9], 2'b00,
                          rv32_isa_pkg::STORE};
      end

      3'b100: begin
        if (!cinstr_i[12]) begin
          if (rs2_zero) begin
            // c.jr -> jalr x0, 0(rs1), reserved for rs1 x0
            expand_o.instr = {12'b0, rd, 3'b000, 5'd0, rv32_isa_pkg::JALR};
            expand_o.illegal = rd_zero;
          end else begin
            // c.mv -> add rd, x0, rs2
            expand_o.instr = {7'b0, rs2, 5'd0, rv32_isa_pkg::F3_ADD, rd, rv32_isa_pkg::OP};
          end
        end else begin
          if (rs2_zero && rd_zero) begin
            expand_o.instr = rv32_isa_pkg::EBREAK_WORD;
          end else if (rs2_zero) begin
            // c.jalr -> jalr ra, 0(rs1)
            expand_o.instr = {12'b0, rd, 3'b000, `RV_REG_RA, rv32_isa_pkg::JALR};
          end else begin
            // c.add, a hint when rd is x0
            expand_o.instr = {7'b0, rs2, rd, rv32_isa_pkg::F3_ADD, rd, rv32_isa_pkg::OP};
          end
        end
      end

      default: begin
        // fldsp, flwsp, fsdsp, fswsp
        expand_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rvc_expander.sv ====
////////////////////////////////////////////////////////////
// RV32C expander for the decode stage
// one fetch word per cycle in, one registered result out
// compressed words are expanded, 32-bit words pass through
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "rvc_expander_cfg.svh"

module rvc_expander (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 valid_i,
  input  rv32_isa_pkg::instr_t instr_i,
  output logic                 valid_o,
  output rv32_isa_pkg::instr_t instr_o,
  output logic                 compressed_o,
  output logic                 illegal_o
);

  rvc_pkg::cinstr_t     cinstr;
  rvc_pkg::quadrant_e   quadrant;
  rvc_pkg::expand_t     exp_q0;
  rvc_pkg::expand_t     exp_q1;
  rvc_pkg::expand_t     exp_q2;
  rvc_pkg::expand_t     exp_sel;
  rvc_pkg::decode_out_t out_q;

  // lower half of the fetch word feeds all three decoders
  assign cinstr   = instr_i[`RV_ILEN/2-1:0];
  assign quadrant = rvc_pkg::quadrant_e'(instr_i[1:0]);

  rvc_decode_q0 u_q0 (.cinstr_i(cinstr), .expand_o(exp_q0));
  rvc_decode_q1 u_q1 (.cinstr_i(cinstr), .expand_o(exp_q1));
  rvc_decode_q2 u_q2 (.cinstr_i(cinstr), .expand_o(exp_q2));

  always_comb begin
    case (quadrant)
      rvc_pkg::Q0: exp_sel = exp_q0;
      rvc_pkg::Q1: exp_sel = exp_q1;
      rvc_pkg::Q2: exp_sel = exp_q2;
      // full-width word goes through untouched
      default:     exp_sel = '{instr: instr_i, illegal: 1'b0};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // output register, one cycle of latency
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q.valid      <= 1'b0;
      out_q.compressed <= 1'b0;
      out_q.illegal    <= 1'b0;
    end else begin
      out_q.valid <= valid_i;
      if (valid_i) begin
        out_q.instr      <= exp_sel.instr;
        out_q.compressed <= (quadrant != rvc_pkg::FULL);
        out_q.illegal    <= exp_sel.illegal;
      end
    end
  end

  assign valid_o      = out_q.valid;
  assign instr_o      = out_q.instr;
  assign compressed_o = out_q.compressed;
  assign illegal_o    = out_q.illegal;

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////
  a_reset_quiet : assert property (@(posedge clk) !arst_n_i |-> !valid_o);

  // only an expanded word can carry the illegal flag
  a_illegal_compressed : assert property (@(posedge clk) disable iff (!arst_n_i)
    illegal_o |-> compressed_o);

  // a 32-bit word comes back one cycle later, unchanged and legal
  a_pass_through : assert property (@(posedge clk) disable iff (!arst_n_i)
    valid_o && !compressed_o |-> !illegal_o && (instr_o == $past(instr_i)));

endmodule

`default_nettype wire

// ==== tb_rvc_expander.sv ====
////////////////////////////////////////////////////////////
// self-checking testbench for the RV32C expander
// reads vectors from the testdata file, drives them with
// pseudo-random idle gaps and checks every registered result
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "rvc_expander_cfg.svh"

module tb_rvc_expander;

  localparam int          MAX_VEC   = 256;
  localparam int          RESET_CYC = 10;
  localparam logic [31:0] LFSR_SEED = 32'h5d29d3c9;

  // what the DUT must return for one issued word
  typedef struct packed {
    rv32_isa_pkg::instr_t instr;
    logic                 compressed;
    logic                 illegal;
  } expect_t;

  logic                 clk;
  logic                 arst_n_i;
  logic                 valid_i;
  rv32_isa_pkg::instr_t instr_i;
  logic                 valid_o;
  rv32_isa_pkg::instr_t instr_o;
  logic                 compressed_o;
  logic                 illegal_o;

  // three words per vector: input, expected word, illegal bit
  logic [`RV_ILEN-1:0] vec_mem [0:3*MAX_VEC-1];
  int                  vec_count = 0;
  int                  out_count = 0;
  logic [31:0]         lfsr;
  expect_t             exp_q [$];
  // valid_i as the DUT sampled it on the last edge
  logic                valid_seen = 1'b0;
  logic                post_reset = 1'b0;

  rvc_expander dut (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .valid_i      (valid_i),
    .instr_i      (instr_i),
    .valid_o      (valid_o),
    .instr_o      (instr_o),
    .compressed_o (compressed_o),
    .illegal_o    (illegal_o)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
  endfunction

  // two LFSR bits give an idle gap of 0..3 cycles
  task automatic draw_gap(output logic [1:0] gap);
    gap = 2'b00;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_next(lfsr);
      gap  = {gap[0], lfsr[0]};
    end
  endtask

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      fail_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, what,
                         actual, expected));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // output monitor, samples on the falling edge
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin : monitor
    expect_t want;
    // outputs quiet in reset and on the first cycle after it
    if (!arst_n_i || post_reset) begin
      check_value(32'(valid_o), 32'd0, "valid_o around reset");
      check_value(32'(compressed_o), 32'd0, "compressed_o around reset");
      check_value(32'(illegal_o), 32'd0, "illegal_o around reset");
    end
    post_reset = !arst_n_i;
    // exactly one cycle of latency
    check_value(32'(valid_o), 32'(valid_seen), "valid_o");
    valid_seen = valid_i && arst_n_i;
    if (valid_o) begin
      want = exp_q.pop_front();
      check_value(32'(compressed_o), 32'(want.compressed), "compressed_o");
      check_value(32'(illegal_o), 32'(want.illegal), "illegal_o");
      if (!want.illegal) begin
        check_value(instr_o, want.instr, "instr_o");
      end
      out_count++;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    logic [1:0]           gap;
    expect_t              want;
    rv32_isa_pkg::instr_t word;
    arst_n_i = 1'b0;
    valid_i  = 1'b0;
    instr_i  = '0;
    lfsr     = LFSR_SEED;

    for (int a = 0; a < 3*MAX_VEC; a++) begin
      vec_mem[a] = 32'hffff_0000 | 32'(a);
    end
    $readmemh("rvc_expander_testdata.txt", vec_mem);
    // the illegal column is 0 or 1 on every real vector
    while (vec_count < MAX_VEC && vec_mem[3*vec_count+2] <= 32'd1) begin
      vec_count++;
    end
    if (vec_count == 0) begin
      fail_run("no test vectors were read from the data file");
    end

    repeat (RESET_CYC) @(posedge clk);
    arst_n_i <= 1'b1;

    for (int v = 0; v < vec_count; v++) begin
      draw_gap(gap);
      repeat (gap) begin
        @(posedge clk);
        valid_i <= 1'b0;
      end
      @(posedge clk);
      word = vec_mem[3*v];
      valid_i <= 1'b1;
      instr_i <= word;
      want.instr      = vec_mem[3*v+1];
      want.compressed = (word[1:0] != 2'b11);
      want.illegal    = vec_mem[3*v+2][0];
      exp_q.push_back(want);
    end
    @(posedge clk);
    valid_i <= 1'b0;

    wait (out_count == vec_count);
    repeat (2) @(negedge clk);
    if (out_count != vec_count) begin
      fail_run($sformatf("** Error at %0t: %0d outputs for %0d inputs", $time,
                         out_count, vec_count));
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

  // at most four cycles per vector, plus reset and drain
  initial begin : watchdog
    wait (vec_count > 0);
    repeat (vec_count * 4 + RESET_CYC + 10) @(posedge clk);
    fail_run("timeout, the outputs did not all arrive in time");
  end

endmodule

`default_nettype wire

// ==== rvc_expander_testdata.txt ====
// input word, expected output word, expected illegal bit
// expected word is ignored on illegal vectors
00000040 00410413 0
00000000 00000000 1
00004144 00452483 0
00005fe0 07c7a403 0
0000c48c 00b4a423 0
00002084 00000000 1
00006084 00000000 1
00008000 00000000 1
dead0001 00000013 0
000012fd fff28293 0
00000501 00050513 0
00002021 008000ef 0
0000bffd fffff06f 0
00005781 fe000793 0
00004015 00500013 0
00006185 000011b7 0
000073fd fffff3b7 0
00006181 00000000 1
00007101 e0010113 0
00006101 00000000 1
0000800d 00345413 0
000084fd 41f4d493 0
0000900d 00000000 1
00009941 ff057513 0
00008c05 40940433 0
00008d2d 00b54533 0
00008e55 00d66633 0
00008f7d 00f77733 0
00009c05 00000000 1
00009c65 00000000 1
0000c099 00048363 0
0000f381 f00790e3 0
00000292 00429293 0
00001292 00000000 1
ffff4532 00c12503 0
00004002 00000000 1
0000c822 00812823 0
0000df86 0e112e23 0
5a5a8082 00008067 0
00008002 00000000 1
0000852e 00b00533 0
00008016 00500033 0
00009002 00100073 0
00009282 000280e7 0
00009636 00d60633 0
0000900e 00300033 0
00002002 00000000 1
00a00093 00a00093 0
12345677 12345677 0
ffffffff ffffffff 0

// ==== rvc_expander.f ====
+incdir+.
rv32_isa_pkg.sv
rvc_pkg.sv
rvc_decode_q0.sv
rvc_decode_q1.sv
rvc_decode_q2.sv
rvc_expander.sv
tb_rvc_expander.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the RV32C expander testbench with Verilator and run it
# exit status is nonzero unless the testbench reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  --top-module tb_rvc_expander \
  -f rvc_expander.f \
  -o tb_rvc_expander \
  && ./obj_dir/tb_rvc_expander | tee /dev/stderr | grep -F "NO ERRORS" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
